// File: verilog.f
+incdir+hw
hw/core_pkg.sv
hw/control_port_bridge.sv
hw/reg_block_decoder.sv
hw/device_id_regs.sv
hw/sram_reg_window.sv
hw/nf2_core.sv
testbench/tb_nf2_core.sv

// File: run_sim.sh
#!/bin/sh
# builds tb_nf2_core with Verilator, runs it and checks sim.log for the pass line
cd "$(dirname "$0")" &&
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert -f verilog.f --top-module tb_nf2_core -o tb_nf2_core &&
./obj_dir/tb_nf2_core > sim.log 2>&1 ||
{ echo "build or simulation error, see sim.log"; exit 1; }
grep -qx "sim passed" sim.log &&
echo "PASS" ||
{ echo "FAIL, see sim.log"; exit 1; }

// File: testbench/tb_nf2_core.sv
`include "core_settings.svh"

module tb_nf2_core;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int REGION_LSB     = `CONTROL_ADDR_WIDTH - `REGION_SEL_BITS;
   localparam int BLOCK_LSB      = REGION_LSB - `CORE_BLOCK_SEL_BITS;
   localparam int ACCESS_TIMEOUT = 64;

   logic                 core_clk_int;
   logic                 reset;
   logic                 control_port_read;
   logic                 control_port_write;
   core_pkg::ctrl_addr_t control_port_address;
   core_pkg::reg_data_t  control_port_writedata;
   logic                 control_port_waitrequest;
   core_pkg::reg_data_t  control_port_readdata;
   logic                 control_port_read_datavalid;

   core_pkg::reg_data_t sram_model [core_pkg::sram_addr_t];
   logic [31:0]         rng_state = 32'd18882;
   int                  errors;
   int                  checks;
   int                  accesses;
   int                  timeouts;
   int                  test_num;
   int                  errors_at_start;

   nf2_core UUT (
      .core_clk_int                (core_clk_int),
      .reset                       (reset),
      .control_port_read           (control_port_read),
      .control_port_write          (control_port_write),
      .control_port_address        (control_port_address),
      .control_port_writedata      (control_port_writedata),
      .control_port_waitrequest    (control_port_waitrequest),
      .control_port_readdata       (control_port_readdata),
      .control_port_read_datavalid (control_port_read_datavalid)
   );

   initial begin
      core_clk_int = 1'b0;
      forever #20 core_clk_int = ~core_clk_int;
   end

   function automatic logic [31:0] next_random();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   function automatic core_pkg::ctrl_addr_t region_addr(input logic [31:0] region,
                                                       input logic [31:0] low);
      core_pkg::ctrl_addr_t a;
      a = '0;
      a[REGION_LSB-1:0] = low[REGION_LSB-1:0];
      a[`CONTROL_ADDR_WIDTH-1:REGION_LSB] = region[`REGION_SEL_BITS-1:0];
      return a;
   endfunction

   function automatic core_pkg::ctrl_addr_t block_addr(input logic [31:0] block,
                                                      input logic [31:0] offset);
      logic [31:0] low;
      low = (block << BLOCK_LSB) | (offset & ((32'd1 << BLOCK_LSB) - 32'd1));
      return region_addr(`CORE_REGION, low);
   endfunction

   // register map model, returns 0 where the value is not known yet
   function automatic logic expected_read(input core_pkg::ctrl_addr_t a,
                                          output core_pkg::reg_data_t value);
      logic [`REGION_SEL_BITS-1:0]     region;
      logic [`CORE_BLOCK_SEL_BITS-1:0] block;
      logic [BLOCK_LSB-1:0]            offset;
      core_pkg::sram_addr_t            idx;
      region = a[`CONTROL_ADDR_WIDTH-1:REGION_LSB];
      block  = a[REGION_LSB-1:BLOCK_LSB];
      offset = a[BLOCK_LSB-1:0];
      idx    = a[`SRAM_ADDR_WIDTH-1:0];
      value  = `UNUSED_REG_VALUE;
      expected_read = 1'b1;
      if (region == `CORE_REGION && block == `DEV_ID_BLOCK) begin
         if (offset == 0) value = `DEVICE_ID;
         else if (offset == 1) value = `DEVICE_REVISION;
         else value = '0;
      end else if (region == `SRAM_REGION) begin
         if (sram_model.exists(idx)) value = sram_model[idx];
         else expected_read = 1'b0;
      end
   endfunction

   task automatic do_access(input logic is_write, input core_pkg::ctrl_addr_t addr,
                            input core_pkg::reg_data_t wdata);
      int                  cycles;
      logic                known;
      logic                done;
      core_pkg::reg_data_t expected;
      if (timeouts != 0) return;
      known = expected_read(addr, expected);
      @(posedge core_clk_int);
      #2;
      control_port_read      = ~is_write;
      control_port_write     = is_write;
      control_port_address   = addr;
      control_port_writedata = wdata;
      cycles = 0;
      done   = 1'b0;
      while (!done && cycles < ACCESS_TIMEOUT) begin
         @(negedge core_clk_int);
         if (!control_port_waitrequest) begin
            done = 1'b1;
         end else begin
            cycles++;
            if (control_port_read_datavalid) begin
               errors++;
               $display("%0t: read_datavalid high while stalled at %h", $time, addr);
            end
         end
      end
      if (!done) begin
         timeouts++;
         $display("%0t: timeout, access at %h never completed", $time, addr);
      end else begin
         accesses++;
         checks++;
         if (is_write && control_port_read_datavalid) begin
            errors++;
            $display("%0t: read_datavalid rose for a write to %h", $time, addr);
         end else if (!is_write && !control_port_read_datavalid) begin
            errors++;
            $display("%0t: read_datavalid missing for a read of %h", $time, addr);
         end else if (!is_write && known && control_port_readdata !== expected) begin
            errors++;
            $display("ERR %0t: read of %h gave %h, expected %h",
                     $time, addr, control_port_readdata, expected);
         end
         if (is_write && addr[`CONTROL_ADDR_WIDTH-1:REGION_LSB] == `SRAM_REGION) begin
            sram_model[addr[`SRAM_ADDR_WIDTH-1:0]] = wdata;
         end
      end
      @(posedge core_clk_int);
      #2;
      control_port_read  = 1'b0;
      control_port_write = 1'b0;
      // strobe must be a single cycle
      @(negedge core_clk_int);
      if (control_port_read_datavalid) begin
         errors++;
         $display("%0t: read_datavalid stayed high after access at %h", $time, addr);
      end
   endtask

   task automatic end_test(input string name);
      test_num++;
      $display("test %0d %s: %0d errors", test_num, name, errors - errors_at_start);
      errors_at_start = errors;
   endtask

   initial begin
      core_pkg::ctrl_addr_t a;
      logic [31:0]          r;
      control_port_read      = 1'b0;
      control_port_write     = 1'b0;
      control_port_address   = '0;
      control_port_writedata = '0;
      reset                  = 1'b1;
      repeat (4) @(posedge core_clk_int);
      #2;
      reset = 1'b0;

      @(negedge core_clk_int);
      checks++;
      if (control_port_waitrequest || control_port_read_datavalid) begin
         errors++;
         $display("ERR %0t: waitrequest or read_datavalid high after reset", $time);
      end
      end_test("reset state");

      for (int i = 0; i < 6; i++) do_access(1'b0, block_addr(`DEV_ID_BLOCK, i), '0);
      do_access(1'b1, block_addr(`DEV_ID_BLOCK, 0), next_random());
      do_access(1'b1, block_addr(`DEV_ID_BLOCK, 1), next_random());
      do_access(1'b0, block_addr(`DEV_ID_BLOCK, 0), '0);
      do_access(1'b0, block_addr(`DEV_ID_BLOCK, 1), '0);
      do_access(1'b0, block_addr(`DEV_ID_BLOCK, next_random()), '0);
      end_test("device id");

      // high offset bits differ between write and read
      for (int i = 0; i < 40; i++) begin
         do_access(1'b1, region_addr(`SRAM_REGION, next_random()), next_random());
      end
      foreach (sram_model[k]) begin
         do_access(1'b0, region_addr(`SRAM_REGION, (next_random() << 8) | 32'(k)), '0);
      end
      end_test("sram window");

      for (int i = 0; i < 16; i++) begin
         r = next_random();
         a = r[0] ? region_addr(2 + 32'(r[1]), next_random())
                  : block_addr(1 + r % 15, next_random());
         do_access(r[2], a, next_random());
      end
      do_access(1'b0, block_addr(`DEV_ID_BLOCK, 0), '0);
      do_access(1'b0, block_addr(`DEV_ID_BLOCK, 1), '0);
      foreach (sram_model[k]) do_access(1'b0, region_addr(`SRAM_REGION, 32'(k)), '0);
      end_test("unused space");

      for (int i = 0; i < 200; i++) begin
         r = next_random();
         case (r[2:0])
            3'd0, 3'd1, 3'd2: a = region_addr(`SRAM_REGION, next_random());
            3'd3, 3'd4:       a = block_addr(`DEV_ID_BLOCK, next_random() % 4);
            3'd5:             a = block_addr(1 + next_random() % 15, next_random());
            3'd6:             a = region_addr(2 + 32'(r[8]), next_random());
            default:          a = region_addr(`CORE_REGION, next_random());
         endcase
         do_access(r[3], a, next_random());
      end
      end_test("random mix");

      $display("accesses %0d, checks %0d, errors %0d, timeouts %0d",
               accesses, checks, errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

// File: hw/nf2_core.sv
`include "core_settings.svh"

module nf2_core (
   input  logic                           core_clk_int,
   input  logic                           reset,
   input  logic                           control_port_read,
   input  logic                           control_port_write,
   input  logic [`CONTROL_ADDR_WIDTH-1:0] control_port_address,
   input  logic [`REG_DATA_WIDTH-1:0]     control_port_writedata,
   output logic                           control_port_waitrequest,
   output logic [`REG_DATA_WIDTH-1:0]     control_port_readdata,
   output logic                           control_port_read_datavalid
);

   // flat widths of one register request and one response
   localparam int REQ_W = 2 + `CONTROL_ADDR_WIDTH + `REG_DATA_WIDTH;
   localparam int RSP_W = 1 + `REG_DATA_WIDTH;

   localparam int NUM_REGIONS     = 1 << `REGION_SEL_BITS;
   localparam int NUM_CORE_BLOCKS = 1 << `CORE_BLOCK_SEL_BITS;
   localparam int REGION_SEL_LSB  = `CONTROL_ADDR_WIDTH - `REGION_SEL_BITS;
   localparam int CORE_SEL_LSB    = REGION_SEL_LSB - `CORE_BLOCK_SEL_BITS;

   localparam logic [NUM_REGIONS-1:0] REGION_MASK =
      NUM_REGIONS'(1 << `CORE_REGION) | NUM_REGIONS'(1 << `SRAM_REGION);
   localparam logic [NUM_CORE_BLOCKS-1:0] CORE_MASK = NUM_CORE_BLOCKS'(1 << `DEV_ID_BLOCK);

   logic [REQ_W-1:0]                      bridge_req;
   logic [RSP_W-1:0]                      bridge_rsp;
   logic [NUM_REGIONS-1:0][REQ_W-1:0]     region_req;
   logic [NUM_REGIONS-1:0][RSP_W-1:0]     region_rsp;
   logic [NUM_CORE_BLOCKS-1:0][REQ_W-1:0] block_req;
   logic [NUM_CORE_BLOCKS-1:0][RSP_W-1:0] block_rsp;

   control_port_bridge bridge (
      .core_clk_int                (core_clk_int),
      .reset                       (reset),
      .control_port_read           (control_port_read),
      .control_port_write          (control_port_write),
      .control_port_address        (control_port_address),
      .control_port_writedata      (control_port_writedata),
      .control_port_waitrequest    (control_port_waitrequest),
      .control_port_readdata       (control_port_readdata),
      .control_port_read_datavalid (control_port_read_datavalid),
      .bus_req                     (bridge_req),
      .bus_rsp                     (bridge_rsp)
   );

   reg_block_decoder #(
      .NUM_OUTPUTS (NUM_REGIONS),
      .SEL_LSB     (REGION_SEL_LSB),
      .USED_MASK   (REGION_MASK)
   ) region_decoder (
      .core_clk_int (core_clk_int),
      .reset        (reset),
      .up_req       (bridge_req),
      .up_rsp       (bridge_rsp),
      .down_req     (region_req),
      .down_rsp     (region_rsp)
   );

   reg_block_decoder #(
      .NUM_OUTPUTS (NUM_CORE_BLOCKS),
      .SEL_LSB     (CORE_SEL_LSB),
      .USED_MASK   (CORE_MASK)
   ) core_block_decoder (
      .core_clk_int (core_clk_int),
      .reset        (reset),
      .up_req       (region_req[`CORE_REGION]),
      .up_rsp       (region_rsp[`CORE_REGION]),
      .down_req     (block_req),
      .down_rsp     (block_rsp)
   );

   device_id_regs device_id (
      .core_clk_int (core_clk_int),
      .reset        (reset),
      .reg_req      (block_req[`DEV_ID_BLOCK]),
      .reg_rsp      (block_rsp[`DEV_ID_BLOCK])
   );

   sram_reg_window sram_window (
      .core_clk_int (core_clk_int),
      .reset        (reset),
      .reg_req      (region_req[`SRAM_REGION]),
      .reg_rsp      (region_rsp[`SRAM_REGION])
   );

   // idle responses for slots the decoders answer themselves
   for (genvar i = 0; i < NUM_REGIONS; i++) begin : g_region_idle
      if (!REGION_MASK[i]) begin : g_tie
         assign region_rsp[i] = '0;
      end
   end

   for (genvar i = 0; i < NUM_CORE_BLOCKS; i++) begin : g_block_idle
      if (!CORE_MASK[i]) begin : g_tie
         assign block_rsp[i] = '0;
      end
   end

endmodule

// File: hw/sram_reg_window.sv
`include "core_settings.svh"

module sram_reg_window (
   input  logic               core_clk_int,
   input  logic               reset,
   input  core_pkg::reg_req_t reg_req,
   output core_pkg::reg_rsp_t reg_rsp
);

   localparam int DEPTH = 1 << `SRAM_ADDR_WIDTH;

   core_pkg::window_state_t state;
   core_pkg::window_state_t state_next;
   core_pkg::reg_data_t     mem [DEPTH];
   core_pkg::reg_data_t     rd_data_q;
   core_pkg::sram_addr_t    idx;
   logic                    start;
   logic                    ack_q;
   logic                    ack_next;

   // upper offset bits are dropped so the window repeats
   assign idx   = reg_req.addr[`SRAM_ADDR_WIDTH-1:0];
   assign start = (state == core_pkg::win_idle) & reg_req.req;

   always_ff @(posedge core_clk_int) begin
      if (reset) begin
         state <= core_pkg::win_idle;
         ack_q <= 1'b0;
      end else begin
         state <= state_next;
         ack_q <= ack_next;
      end
   end

   always_comb begin
      state_next = state;
      ack_next   = ack_q;
      case (state)
         core_pkg::win_idle: begin
            ack_next = 1'b0;
            if (reg_req.req) begin
               ack_next   = 1'b1;
               state_next = core_pkg::win_ack_hold;
            end
         end
         core_pkg::win_ack_hold: begin
            // hold ack until the requester lets go
            if (!reg_req.req) begin
               ack_next   = 1'b0;
               state_next = core_pkg::win_idle;
            end
         end
         default: begin
            ack_next   = 1'b0;
            state_next = core_pkg::win_idle;
         end
      endcase
   end

   // one access per request on its first req cycle
   always_ff @(posedge core_clk_int) begin
      if (start && !reg_req.rd_wr_l) begin
         mem[idx] <= reg_req.wr_data;
      end
      if (start && reg_req.rd_wr_l) begin
         rd_data_q <= mem[idx];
      end
   end

   assign reg_rsp = '{ack: ack_q, rd_data: rd_data_q};

   a_ack_after_req: assert property (@(posedge core_clk_int) disable iff (reset)
      $rose(reg_rsp.ack) |-> $past(reg_req.req) && reg_req.req);

endmodule

// File: hw/device_id_regs.sv
`include "core_settings.svh"

module device_id_regs (
   input  logic               core_clk_int,
   input  logic               reset,
   input  core_pkg::reg_req_t reg_req,
   output core_pkg::reg_rsp_t reg_rsp
);

   // word offset inside one core block
   localparam int OFFSET_W = `CONTROL_ADDR_WIDTH - `REGION_SEL_BITS - `CORE_BLOCK_SEL_BITS;

   logic [OFFSET_W-1:0] offset;
   logic                ack_q;
   core_pkg::reg_data_t rd_data_q;

   assign offset = reg_req.addr[OFFSET_W-1:0];

   always_ff @(posedge core_clk_int) begin
      if (reset) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= reg_req.req;
      end
   end

   // writes get the ack and nothing else
   always_ff @(posedge core_clk_int) begin
      if (reg_req.req && reg_req.rd_wr_l) begin
         case (offset)
            OFFSET_W'(0): rd_data_q <= `DEVICE_ID;
            OFFSET_W'(1): rd_data_q <= `DEVICE_REVISION;
            default:      rd_data_q <= '0;
         endcase
      end
   end

   assign reg_rsp = '{ack: ack_q, rd_data: rd_data_q};

endmodule

// File: hw/reg_block_decoder.sv
`include "core_settings.svh"

module reg_block_decoder #(
   parameter int                     NUM_OUTPUTS = 4,
   parameter int                     SEL_LSB     = 22,
   parameter logic [NUM_OUTPUTS-1:0] USED_MASK   = '1
) (
   input  logic                                 core_clk_int,
   input  logic                                 reset,
   input  core_pkg::reg_req_t                   up_req,
   output core_pkg::reg_rsp_t                   up_rsp,
   output core_pkg::reg_req_t [NUM_OUTPUTS-1:0] down_req,
   input  core_pkg::reg_rsp_t [NUM_OUTPUTS-1:0] down_rsp
);

   localparam int SEL_W = $clog2(NUM_OUTPUTS);

   logic [SEL_W-1:0]       sel_in;
   logic [SEL_W-1:0]       sel_q;
   logic                   used_in;
   logic                   unused_hit;
   logic [NUM_OUTPUTS-1:0] down_on;
   logic [NUM_OUTPUTS-1:0] down_ack;
   logic                   ack_q;
   core_pkg::reg_data_t    rd_data_q;
   logic                   rd_wr_l_q;
   core_pkg::ctrl_addr_t   addr_q;
   core_pkg::reg_data_t    wr_data_q;

   assign sel_in     = up_req.addr[SEL_LSB +: SEL_W];
   assign used_in    = USED_MASK[sel_in];
   assign unused_hit = up_req.req & ~used_in;

   always_ff @(posedge core_clk_int) begin
      if (reset) begin
         down_on <= '0;
         sel_q   <= '0;
         ack_q   <= 1'b0;
      end else begin
         down_on <= '0;
         if (up_req.req && used_in) begin
            down_on[sel_in] <= 1'b1;
         end
         // sel_q holds after req drops so the ack release is tracked
         if (up_req.req) begin
            sel_q <= sel_in;
         end
         // unserved blocks are answered here
         ack_q <= unused_hit | (USED_MASK[sel_q] & down_rsp[sel_q].ack);
      end
   end

   always_ff @(posedge core_clk_int) begin
      if (up_req.req) begin
         rd_wr_l_q <= up_req.rd_wr_l;
         addr_q    <= up_req.addr;
         wr_data_q <= up_req.wr_data;
      end
      if (unused_hit) begin
         rd_data_q <= `UNUSED_REG_VALUE;
      end else begin
         rd_data_q <= down_rsp[sel_q].rd_data;
      end
   end

   for (genvar i = 0; i < NUM_OUTPUTS; i++) begin : g_down
      assign down_req[i] = '{
         req:     down_on[i],
         rd_wr_l: rd_wr_l_q,
         addr:    addr_q,
         wr_data: wr_data_q
      };
      assign down_ack[i] = down_rsp[i].ack;
   end

   assign up_rsp = '{ack: ack_q, rd_data: rd_data_q};

   // a block stays busy until its ack drops
   a_single_down_req: assert property (@(posedge core_clk_int) disable iff (reset)
      $onehot0(down_on | (down_ack & USED_MASK)));

   // ack only rises in answer to a pending request
   a_ack_needs_req: assert property (@(posedge core_clk_int) disable iff (reset)
      $rose(up_rsp.ack) |-> $past(up_req.req));

endmodule

// File: hw/control_port_bridge.sv
module control_port_bridge (
   input  logic                 core_clk_int,
   input  logic                 reset,
   input  logic                 control_port_read,
   input  logic                 control_port_write,
   input  core_pkg::ctrl_addr_t control_port_address,
   input  core_pkg::reg_data_t  control_port_writedata,
   output logic                 control_port_waitrequest,
   output core_pkg::reg_data_t  control_port_readdata,
   output logic                 control_port_read_datavalid,
   output core_pkg::reg_req_t   bus_req,
   input  core_pkg::reg_rsp_t   bus_rsp
);

   core_pkg::bridge_state_t state;
   logic                    access;
   logic                    accept;
   logic                    req_on;
   logic                    done_q;
   logic                    rd_valid_q;
   logic                    rd_wr_l_q;
   core_pkg::ctrl_addr_t    addr_q;
   core_pkg::reg_data_t     wr_data_q;
   core_pkg::reg_data_t     rd_data_q;

   assign access = control_port_read | control_port_write;
   assign accept = (state == core_pkg::br_idle) & access;

   always_ff @(posedge core_clk_int) begin
      if (reset) begin
         state      <= core_pkg::br_idle;
         req_on     <= 1'b0;
         done_q     <= 1'b0;
         rd_valid_q <= 1'b0;
      end else begin
         done_q     <= 1'b0;
         rd_valid_q <= 1'b0;
         case (state)
            core_pkg::br_idle: begin
               if (access) begin
                  req_on <= 1'b1;
                  state  <= core_pkg::br_wait_ack;
               end
            end
            core_pkg::br_wait_ack: begin
               if (bus_rsp.ack) begin
                  // completion is signalled to the host next cycle
                  req_on     <= 1'b0;
                  done_q     <= 1'b1;
                  rd_valid_q <= rd_wr_l_q;
                  state      <= core_pkg::br_wait_release;
               end
            end
            core_pkg::br_wait_release: begin
               // four-phase cycle closes once ack drops
               if (!bus_rsp.ack) begin
                  state <= core_pkg::br_idle;
               end
            end
            default: begin
               state <= core_pkg::br_idle;
            end
         endcase
      end
   end

   // write wins over read when both are raised
   always_ff @(posedge core_clk_int) begin
      if (accept) begin
         addr_q    <= control_port_address;
         wr_data_q <= control_port_writedata;
         rd_wr_l_q <= ~control_port_write;
      end
      if (state == core_pkg::br_wait_ack && bus_rsp.ack) begin
         rd_data_q <= bus_rsp.rd_data;
      end
   end

   // stalls any access except in its completion cycle
   assign control_port_waitrequest = access & ~done_q;

   assign control_port_readdata       = rd_data_q;
   assign control_port_read_datavalid = rd_valid_q;

   assign bus_req = '{
      req:     req_on,
      rd_wr_l: rd_wr_l_q,
      addr:    addr_q,
      wr_data: wr_data_q
   };

   // strobe only in the completion cycle of a read the host still holds
   a_valid_not_stalled: assert property (@(posedge core_clk_int) disable iff (reset)
      control_port_read_datavalid |->
         !control_port_waitrequest && control_port_read && !control_port_write);

endmodule

// File: hw/core_pkg.sv
`include "core_settings.svh"

package core_pkg;

   typedef logic [`REG_DATA_WIDTH-1:0]     reg_data_t;
   typedef logic [`CONTROL_ADDR_WIDTH-1:0] ctrl_addr_t;
   typedef logic [`SRAM_ADDR_WIDTH-1:0]    sram_addr_t;

   // one hop of the register tree, requester side
   typedef struct packed {
      logic       req;
      logic       rd_wr_l;
      ctrl_addr_t addr;
      reg_data_t  wr_data;
   } reg_req_t;

   // responder side, rd_data only meaningful with ack on a read
   typedef struct packed {
      logic      ack;
      reg_data_t rd_data;
   } reg_rsp_t;

   typedef enum logic [1:0] {
      br_idle,
      br_wait_ack,
      br_wait_release
   } bridge_state_t;

   typedef enum logic {
      win_idle,
      win_ack_hold
   } window_state_t;

endpackage

// File: hw/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// host side widths
`define CONTROL_ADDR_WIDTH   24
`define REG_DATA_WIDTH       32

// address tree, region field on top, core block field below it
`define REGION_SEL_BITS      2
`define CORE_BLOCK_SEL_BITS  4

// region indices
`define CORE_REGION          0
`define SRAM_REGION          1

// core block indices
`define DEV_ID_BLOCK         0

// sram window holds 2**SRAM_ADDR_WIDTH words
`define SRAM_ADDR_WIDTH      8

// identification
`define DEVICE_ID            32'h4e46_3200
`define DEVICE_REVISION      32'h0000_0103

// read value of blocks nobody serves
`define UNUSED_REG_VALUE     32'hdead_beef

`endif
